// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert --timing -j 0
TOP := tb_pat_core
FILELIST := project.f
LOG := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/inst_mem.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/pat_core.sv
test/pat_core_asserts.sv
test/pat_checker.sv
test/tb_pat_core.sv

// File: test/pat_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pat_checker
(
	input wire clk,
	input wire reset,
	input wire i_imem_write,
	input wire core_pkg::iaddr_t i_imem_addr,
	input wire isa_pkg::instr_t i_imem_data,
	input wire core_pkg::data_t i_in0,
	input wire core_pkg::data_t i_in1,
	input wire core_pkg::data_t i_in2,
	input wire core_pkg::data_t i_out,
	input wire i_out_strobe,
	input wire core_pkg::iaddr_t i_pc,
	input wire i_end_test,
	output int o_errors,
	output int o_failed_tests
);

isa_pkg::instr_t prog [16]; // programs stay within 16 words
core_pkg::data_t regs [8]; // the DUT registers survive reset, so these do too
core_pkg::data_t exp_q [$];
int link;
logic z;
logic n;
logic reset_q = 1'b1;
int test_errors = 0;
int test_num = 0;
int error_total = 0;
int failed_total = 0;

assign o_errors = error_total;
assign o_failed_tests = failed_total;

// ==============================
// ISA model
// ==============================
task automatic run_model();
	int pc;
	int next;
	int steps;
	isa_pkg::instr_t w;
	isa_pkg::reg_idx_t rn;
	isa_pkg::imm8_t imm;
	isa_pkg::opcode_t op8;
	isa_pkg::opcode_t op3;
	core_pkg::data_t b;
	logic [2:0] amt;
	logic ok;
	z = 1'b0;
	n = 1'b0;
	pc = 0;
	exp_q.delete();
	for (steps = 0; steps < 100; steps++)
	begin
		w = prog[pc];
		rn = w[22:20];
		op8 = w[11:8];
		imm = w[7:0];
		op3 = imm[7:4];
		case (w[14:13])
			isa_pkg::COND_Z: ok = z;
			isa_pkg::COND_NZ: ok = !z;
			isa_pkg::COND_N: ok = n;
			default: ok = 1'b1;
		endcase
		next = pc + 1;
		if (ok && op8 != isa_pkg::OP_PREFIX)
		begin
			b = op8[0] ? regs[imm[2:0]] : imm; // odd codes take a register
			case (op8)
				isa_pkg::OP_ORI, isa_pkg::OP_ORR: regs[rn] = regs[rn] | b;
				isa_pkg::OP_ANDI, isa_pkg::OP_ANDR: regs[rn] = regs[rn] & b;
				isa_pkg::OP_ADDI, isa_pkg::OP_ADDR: regs[rn] = regs[rn] + b;
				isa_pkg::OP_SUBI, isa_pkg::OP_SUBR: regs[rn] = regs[rn] - b;
				isa_pkg::OP_LDI: regs[rn] = imm;
				isa_pkg::OP_BF: next = pc + int'($signed(imm));
				isa_pkg::OP_CALL:
				begin
					link = pc + 1;
					next = pc + int'($signed(imm));
				end
				default: ;
			endcase
		end
		else if (ok && op3 != isa_pkg::OP_PREFIX)
		begin
			b = op3[0] ? regs[imm[2:0]] : {5'd0, imm[2:0]};
			amt = {1'b0, b[1:0]} + 3'd1;
			// ones fill is the complement shifted with zeros
			case (op3)
				isa_pkg::I3_SHLZI, isa_pkg::I3_SHLZR: regs[rn] = regs[rn] << amt;
				isa_pkg::I3_SHLOI, isa_pkg::I3_SHLOR: regs[rn] = ~(~regs[rn] << amt);
				isa_pkg::I3_SHRZI, isa_pkg::I3_SHRZR: regs[rn] = regs[rn] >> amt;
				isa_pkg::I3_SHROI, isa_pkg::I3_SHROR: regs[rn] = ~(~regs[rn] >> amt);
				isa_pkg::I3_IN: regs[rn] = (imm[2:0] == 3'b010) ? i_in1 :
					(imm[2:0] == 3'b100) ? i_in2 : i_in0;
				isa_pkg::I3_OUT: exp_q.push_back(regs[rn]);
				default: ;
			endcase
		end
		else if (ok)
		begin
			case (imm[3:0])
				isa_pkg::I0_NOT: regs[rn] = ~regs[rn];
				isa_pkg::I0_TEST:
				begin
					z = (regs[rn] == 8'd0);
					n = regs[rn][7];
				end
				isa_pkg::I0_RETURN: next = link;
				default: ;
			endcase
		end
		if (next == pc)
			break; // reached the closing loop
		if (next < 0 || next > 15)
		begin
			$display("model left the program at address %0d", next);
			test_errors++;
			break;
		end
		pc = next;
	end
endtask

// ==============================
// comparison
// ==============================
always @(posedge clk)
begin
	if (i_imem_write)
		prog[i_imem_addr[3:0]] = i_imem_data;
	if (reset_q && !reset)
	begin
		run_model();
		if (i_pc != '0)
		begin
			$display("CHECK FAILED o_pc: got %h expected %h", i_pc, 10'h000);
			test_errors++;
		end
	end
	if (!reset && i_out_strobe)
	begin
		if (exp_q.size() == 0)
		begin
			$display("extra out strobe with value %h", i_out);
			test_errors++;
		end
		else if (i_out !== exp_q[0])
		begin
			$display("CHECK FAILED o_out: got %h expected %h", i_out, exp_q[0]);
			test_errors++;
			void'(exp_q.pop_front());
		end
		else
			void'(exp_q.pop_front());
	end
	if (i_end_test)
	begin
		if (exp_q.size() != 0)
		begin
			$display("%0d expected out strobes never came", exp_q.size());
			test_errors++;
		end
		$display("test %0d finished with %0d errors", test_num, test_errors);
		error_total = error_total + test_errors;
		if (test_errors != 0)
			failed_total = failed_total + 1;
		test_errors = 0;
		test_num++;
	end
	reset_q <= reset;
end

endmodule

`default_nettype wire

// File: test/pat_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module pat_core_asserts
(
	input wire clk,
	input wire reset,
	input wire i_jump,
	input wire i_out_strobe
);

int unsigned fail_count = 0; // read by the testbench top

// ==============================
// pipeline control properties
// ==============================
a_quiet_in_reset: assert property (@(posedge clk) reset ##1 reset |-> !i_jump && !i_out_strobe)
	else
	begin
		$error("jump or out strobe while reset is high");
		fail_count++;
	end

a_jump_single: assert property (@(posedge clk) disable iff (reset) i_jump |=> !i_jump)
	else
	begin
		$error("jump held for two cycles");
		fail_count++;
	end

// the two slots behind a jump are squashed, so neither of them strobes
a_no_strobe_after_jump: assert property (@(posedge clk) disable iff (reset)
	$past(i_jump, 2) || $past(i_jump, 3) |-> !i_out_strobe)
	else
	begin
		$error("out strobe from a slot squashed by a jump");
		fail_count++;
	end

endmodule

bind execute_stage pat_core_asserts i_asserts
(
	.clk(clk),
	.reset(reset),
	.i_jump(o_jump),
	.i_out_strobe(o_out_strobe)
);

`default_nettype wire

// File: test/tb_pat_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pat_core;

localparam int NUM_ROUNDS = 5;
localparam int NUM_TESTS = 1 + NUM_ROUNDS * 5;
localparam int RUN_CYCLES = 200;

logic clk = 1'b0;
logic reset = 1'b1;
logic imem_write = 1'b0;
core_pkg::iaddr_t imem_addr = '0;
isa_pkg::instr_t imem_data = '0;
core_pkg::data_t in0 = '0;
core_pkg::data_t in1 = '0;
core_pkg::data_t in2 = '0;
logic end_test = 1'b0;
core_pkg::data_t out;
logic out_strobe;
core_pkg::iaddr_t pc;
logic jump;
int errors;
int failed_tests;
int seed = 32'hb937f998;
isa_pkg::instr_t prog_q [$];

always #2 clk = ~clk;

pat_core i_pat_core
(
	.clk(clk),
	.reset(reset),
	.i_imem_write(imem_write),
	.i_imem_addr(imem_addr),
	.i_imem_data(imem_data),
	.i_in0(in0),
	.i_in1(in1),
	.i_in2(in2),
	.o_out(out),
	.o_out_strobe(out_strobe),
	.o_pc(pc),
	.o_jump(jump)
);

pat_checker i_checker
(
	.clk(clk),
	.reset(reset),
	.i_imem_write(imem_write),
	.i_imem_addr(imem_addr),
	.i_imem_data(imem_data),
	.i_in0(in0),
	.i_in1(in1),
	.i_in2(in2),
	.i_out(out),
	.i_out_strobe(out_strobe),
	.i_pc(pc),
	.i_end_test(end_test),
	.o_errors(errors),
	.o_failed_tests(failed_tests)
);

// ==============================
// program encoding
// ==============================
function automatic logic [31:0] rnd(input int unsigned range);
	logic [31:0] r;
	r = $random(seed);
	return r % range;
endfunction

function automatic isa_pkg::reg_idx_t pick_reg(input int unsigned range);
	logic [31:0] r;
	r = rnd(range);
	return r[2:0];
endfunction

function automatic isa_pkg::cond_t pick_cond();
	logic [31:0] r;
	r = rnd(4);
	return r[1:0];
endfunction

function automatic isa_pkg::imm8_t pick_byte();
	logic [31:0] r;
	r = rnd(256);
	return r[7:0];
endfunction

function automatic isa_pkg::instr_t enc_i8(input isa_pkg::reg_idx_t rn,
	input isa_pkg::cond_t c, input isa_pkg::opcode_t op, input isa_pkg::imm8_t imm);
	return {rn, 5'd0, c, 1'b0, op, imm};
endfunction

function automatic isa_pkg::instr_t enc_i3(input isa_pkg::reg_idx_t rn,
	input isa_pkg::cond_t c, input isa_pkg::opcode_t op3, input logic [2:0] low);
	return enc_i8(rn, c, isa_pkg::OP_PREFIX, {op3, 1'b0, low});
endfunction

function automatic isa_pkg::instr_t enc_i0(input isa_pkg::reg_idx_t rn,
	input isa_pkg::opcode_t op0);
	return enc_i8(rn, isa_pkg::COND_AL, isa_pkg::OP_PREFIX, {isa_pkg::OP_PREFIX, op0});
endfunction

task automatic build_program(input int kind);
	logic [31:0] r;
	logic [31:0] off;
	isa_pkg::reg_idx_t rn;
	int i;
	prog_q.delete();
	case (kind)
		0: for (i = 0; i < 8; i++)
			prog_q.push_back(enc_i8(isa_pkg::reg_idx_t'(i), isa_pkg::COND_AL,
				isa_pkg::OP_LDI, pick_byte()));
		1: for (i = 0; i < 7; i++)
		begin
			r = rnd(9); // ori through ldi
			rn = pick_reg(4);
			prog_q.push_back(enc_i8(rn, isa_pkg::COND_AL, r[3:0], pick_byte()));
			prog_q.push_back(enc_i3(rn, isa_pkg::COND_AL, isa_pkg::I3_OUT, 3'd0)); // result out
		end
		2: for (i = 0; i < 7; i++)
		begin
			r = rnd(9);
			off = rnd(3);
			rn = pick_reg(4);
			if (r < 8)
				prog_q.push_back(enc_i3(rn, isa_pkg::COND_AL, r[3:0], pick_reg(8)));
			else
				prog_q.push_back(enc_i3(rn, isa_pkg::COND_AL, isa_pkg::I3_IN,
					3'b001 << off[1:0]));
			prog_q.push_back(enc_i3(rn, isa_pkg::COND_AL, isa_pkg::I3_OUT, 3'd0));
		end
		3: for (i = 0; i < 3; i++)
		begin
			prog_q.push_back(enc_i0(pick_reg(8), isa_pkg::I0_TEST));
			prog_q.push_back(enc_i8(pick_reg(4), pick_cond(), isa_pkg::OP_ADDI, pick_byte()));
			prog_q.push_back(enc_i3(pick_reg(4), pick_cond(), isa_pkg::I3_OUT, 3'd0));
			prog_q.push_back(enc_i3(pick_reg(4), isa_pkg::COND_AL, isa_pkg::I3_OUT, 3'd0));
		end
		4: for (i = 0; i < 15; i++)
		begin
			r = rnd(4);
			off = 1 + rnd((15 - i) < 7 ? (15 - i) : 7); // stays inside the program
			case (r)
				0: prog_q.push_back(enc_i8(3'd0, pick_cond(), isa_pkg::OP_BF, off[7:0]));
				1: prog_q.push_back(enc_i0(pick_reg(8), isa_pkg::I0_TEST));
				2: prog_q.push_back(enc_i8(pick_reg(8), isa_pkg::COND_AL, isa_pkg::OP_ADDI,
					pick_byte()));
				default: prog_q.push_back(enc_i3(pick_reg(8), isa_pkg::COND_AL,
					isa_pkg::I3_OUT, 3'd0));
			endcase
		end
		default:
		begin
			// main at 0, subroutine at 8 returning to 3
			prog_q.push_back(enc_i8(3'd1, isa_pkg::COND_AL, isa_pkg::OP_LDI, pick_byte()));
			prog_q.push_back(enc_i3(3'd1, isa_pkg::COND_AL, isa_pkg::I3_OUT, 3'd0));
			prog_q.push_back(enc_i8(3'd0, isa_pkg::COND_AL, isa_pkg::OP_CALL, 8'd6));
			prog_q.push_back(enc_i8(3'd1, isa_pkg::COND_AL, isa_pkg::OP_ADDI, 8'd1));
			prog_q.push_back(enc_i3(3'd1, isa_pkg::COND_AL, isa_pkg::I3_OUT, 3'd0));
			prog_q.push_back(enc_i8(3'd0, isa_pkg::COND_AL, isa_pkg::OP_BF, 8'd0));
			prog_q.push_back(isa_pkg::INSTR_NOP);
			prog_q.push_back(isa_pkg::INSTR_NOP);
			prog_q.push_back(enc_i8(3'd1, isa_pkg::COND_AL, isa_pkg::OP_ADDI, pick_byte()));
			prog_q.push_back(enc_i3(3'd1, isa_pkg::COND_AL, isa_pkg::I3_OUT, 3'd0));
			prog_q.push_back(enc_i0(3'd0, isa_pkg::I0_RETURN));
		end
	endcase
	if (kind != 5)
		prog_q.push_back(enc_i8(3'd0, isa_pkg::COND_AL, isa_pkg::OP_BF, 8'd0)); // closing loop
endtask

// ==============================
// test sequence
// ==============================
task automatic run_test(input int kind);
	logic [31:0] r;
	int i;
	build_program(kind);
	@(posedge clk);
	reset <= 1'b1;
	r = $random(seed);
	in0 <= r[7:0];
	in1 <= r[15:8];
	in2 <= r[23:16];
	for (i = 0; i < 16; i++)
	begin
		imem_write <= (i < prog_q.size());
		imem_addr <= core_pkg::iaddr_t'(i);
		imem_data <= (i < prog_q.size()) ? prog_q[i] : isa_pkg::INSTR_NOP;
		@(posedge clk);
	end
	imem_write <= 1'b0;
	reset <= 1'b0;
	repeat (RUN_CYCLES) @(posedge clk);
	end_test <= 1'b1;
	@(posedge clk);
	end_test <= 1'b0;
endtask

initial
begin
	int round;
	int kind;
	int total_errors;
	run_test(0);
	for (round = 0; round < NUM_ROUNDS; round++)
		for (kind = 1; kind <= 5; kind++)
			run_test(kind);
	@(posedge clk);
	total_errors = errors + int'(i_pat_core.u_execute.i_asserts.fail_count);
	$display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, total_errors);
	if (total_errors == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

// watchdog
initial
begin
	#(NUM_TESTS * (16 + 16 + RUN_CYCLES) * 4);
	$display("watchdog expired before the tests finished");
	$display("TESTBENCH FAILED");
	$finish;
end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
(
	input wire core_pkg::data_t i_a,
	input wire core_pkg::data_t i_b,
	input wire core_pkg::alu_sel_t i_sel,
	output core_pkg::data_t o_y
);

logic [2:0] amount;
core_pkg::data_t fill_low;
core_pkg::data_t fill_high;

assign amount = {1'b0, i_b[1:0]} + 3'd1; // shifts by 1 to 4

// ones shifted in for the fill-with-ones kinds
assign fill_low = ~({core_pkg::DATA_WIDTH{1'b1}} << amount);
assign fill_high = ~({core_pkg::DATA_WIDTH{1'b1}} >> amount);

always_comb
begin
	case (i_sel)
		core_pkg::ALU_OR: o_y = i_a | i_b;
		core_pkg::ALU_AND: o_y = i_a & i_b;
		core_pkg::ALU_NOT: o_y = ~i_a;
		core_pkg::ALU_ADD: o_y = i_a + i_b;
		core_pkg::ALU_SUB: o_y = i_a - i_b;
		core_pkg::ALU_SHLZ: o_y = i_a << amount;
		core_pkg::ALU_SHLO: o_y = (i_a << amount) | fill_low;
		core_pkg::ALU_SHRZ: o_y = i_a >> amount;
		core_pkg::ALU_SHRO: o_y = (i_a >> amount) | fill_high;
		core_pkg::ALU_PASS: o_y = i_a;
		default: o_y = i_a;
	endcase
end

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int DATA_WIDTH = 8;
	localparam int IADDR_WIDTH = 10;
	localparam int NUM_REGS = 8;
	localparam int IMEM_DEPTH = 1024;
	localparam int NUM_READ_PORTS = 2; // rn and the register-form source
	localparam int ALU_SEL_WIDTH = 4;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [IADDR_WIDTH-1:0] iaddr_t;
	typedef logic [ALU_SEL_WIDTH-1:0] alu_sel_t;

	// alu function select
	localparam alu_sel_t ALU_OR = 4'd0;
	localparam alu_sel_t ALU_AND = 4'd1;
	localparam alu_sel_t ALU_NOT = 4'd2;
	localparam alu_sel_t ALU_ADD = 4'd3;
	localparam alu_sel_t ALU_SUB = 4'd4;
	localparam alu_sel_t ALU_SHLZ = 4'd5;
	localparam alu_sel_t ALU_SHLO = 4'd6;
	localparam alu_sel_t ALU_SHRZ = 4'd7;
	localparam alu_sel_t ALU_SHRO = 4'd8;
	localparam alu_sel_t ALU_PASS = 4'd9;

	typedef enum logic {FETCH_RUN, FETCH_SQUASH} fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
(
	input wire clk,
	input wire reset,
	input wire isa_pkg::instr_t i_instr,
	input wire core_pkg::iaddr_t i_instr_addr,
	input wire i_valid,
	input wire i_jump,
	output isa_pkg::reg_idx_t o_read_reg [core_pkg::NUM_READ_PORTS],
	input wire core_pkg::data_t i_read_data [core_pkg::NUM_READ_PORTS],
	input wire i_wb_en,
	input wire isa_pkg::reg_idx_t i_wb_reg,
	input wire core_pkg::data_t i_wb_data,
	input wire core_pkg::data_t i_in0,
	input wire core_pkg::data_t i_in1,
	input wire core_pkg::data_t i_in2,
	output logic o_valid,
	output isa_pkg::cond_t o_cond,
	output isa_pkg::reg_idx_t o_dest,
	output core_pkg::iaddr_t o_instr_addr,
	output isa_pkg::imm8_t o_imm8,
	output core_pkg::data_t o_op_a,
	output core_pkg::data_t o_op_b,
	output core_pkg::alu_sel_t o_alu_sel,
	output logic o_write_reg,
	output logic o_is_out,
	output logic o_is_test,
	output logic o_is_bf,
	output logic o_is_call,
	output logic o_is_return
);

isa_pkg::reg_idx_t rn;
isa_pkg::reg_idx_t rm; // imm[2:0] as a register number
isa_pkg::cond_t cond;
isa_pkg::opcode_t op8;
isa_pkg::opcode_t op3;
isa_pkg::opcode_t op0;
isa_pkg::imm8_t imm;
logic is_i8;
logic is_i3;
logic src_reg;
core_pkg::data_t reg_a;
core_pkg::data_t reg_b;
core_pkg::data_t in_sel;
core_pkg::data_t op_a;
core_pkg::data_t op_b;
core_pkg::alu_sel_t alu_sel;
logic write_reg;
logic is_out;
logic is_test;
logic is_bf;
logic is_call;
logic is_return;

// ==============================
// field split and operands
// ==============================
assign rn = i_instr[22:20];
assign cond = i_instr[14:13];
assign op8 = i_instr[11:8];
assign imm = i_instr[7:0];
assign op3 = imm[7:4];
assign op0 = imm[3:0];
assign rm = imm[2:0];

// prefix nibbles escape to the smaller spaces
assign is_i8 = (op8 != isa_pkg::OP_PREFIX);
assign is_i3 = !is_i8 && (op3 != isa_pkg::OP_PREFIX);
assign src_reg = is_i8 ? (!op8[3] && op8[0]) : (is_i3 && !op3[3] && op3[0]);

assign o_read_reg[0] = rn;
assign o_read_reg[1] = rm;

// result committing in this same cycle wins
assign reg_a = (i_wb_en && i_wb_reg == rn) ? i_wb_data : i_read_data[0];
assign reg_b = (i_wb_en && i_wb_reg == rm) ? i_wb_data : i_read_data[1];

always_comb
begin
	case (rm)
		3'b001: in_sel = i_in0;
		3'b010: in_sel = i_in1;
		3'b100: in_sel = i_in2;
		default: in_sel = i_in0; // not one-hot
	endcase
end

assign op_a = (is_i8 && op8 == isa_pkg::OP_LDI) ? '0 :
	(is_i3 && op3 == isa_pkg::I3_IN) ? in_sel : reg_a;
assign op_b = src_reg ? reg_b : (is_i8 ? imm : {5'd0, rm});

// ==============================
// operation decode
// ==============================
always_comb
begin
	alu_sel = core_pkg::ALU_PASS;
	write_reg = 1'b0;
	is_out = 1'b0;
	is_test = 1'b0;
	is_bf = 1'b0;
	is_call = 1'b0;
	is_return = 1'b0;
	if (is_i8)
	begin
		case (op8)
			isa_pkg::OP_ORI, isa_pkg::OP_ORR, isa_pkg::OP_LDI:
			begin
				alu_sel = core_pkg::ALU_OR; // ldi is or with zero
				write_reg = 1'b1;
			end
			isa_pkg::OP_ANDI, isa_pkg::OP_ANDR:
			begin
				alu_sel = core_pkg::ALU_AND;
				write_reg = 1'b1;
			end
			isa_pkg::OP_ADDI, isa_pkg::OP_ADDR:
			begin
				alu_sel = core_pkg::ALU_ADD;
				write_reg = 1'b1;
			end
			isa_pkg::OP_SUBI, isa_pkg::OP_SUBR:
			begin
				alu_sel = core_pkg::ALU_SUB;
				write_reg = 1'b1;
			end
			isa_pkg::OP_BF: is_bf = 1'b1;
			isa_pkg::OP_CALL: is_call = 1'b1;
			default: is_bf = 1'b0; // unused codes do nothing
		endcase
	end
	else if (is_i3)
	begin
		write_reg = 1'b1;
		case (op3)
			isa_pkg::I3_SHLZI, isa_pkg::I3_SHLZR: alu_sel = core_pkg::ALU_SHLZ;
			isa_pkg::I3_SHLOI, isa_pkg::I3_SHLOR: alu_sel = core_pkg::ALU_SHLO;
			isa_pkg::I3_SHRZI, isa_pkg::I3_SHRZR: alu_sel = core_pkg::ALU_SHRZ;
			isa_pkg::I3_SHROI, isa_pkg::I3_SHROR: alu_sel = core_pkg::ALU_SHRO;
			isa_pkg::I3_IN: alu_sel = core_pkg::ALU_PASS; // input already on a
			isa_pkg::I3_OUT:
			begin
				write_reg = 1'b0;
				is_out = 1'b1;
			end
			default: write_reg = 1'b0;
		endcase
	end
	else
	begin
		case (op0)
			isa_pkg::I0_NOT:
			begin
				alu_sel = core_pkg::ALU_NOT;
				write_reg = 1'b1;
			end
			isa_pkg::I0_TEST: is_test = 1'b1;
			isa_pkg::I0_RETURN: is_return = 1'b1;
			isa_pkg::I0_NOP: write_reg = 1'b0;
			default: write_reg = 1'b0;
		endcase
	end
end

// slot behind a taken jump is dropped
always_ff @(posedge clk)
begin
	if (reset)
		o_valid <= 1'b0;
	else
		o_valid <= i_valid && !i_jump;
end

always_ff @(posedge clk)
begin
	o_cond <= cond;
	o_dest <= rn;
	o_instr_addr <= i_instr_addr;
	o_imm8 <= imm;
	o_op_a <= op_a;
	o_op_b <= op_b;
	o_alu_sel <= alu_sel;
	o_write_reg <= write_reg;
	o_is_out <= is_out;
	o_is_test <= is_test;
	o_is_bf <= is_bf;
	o_is_call <= is_call;
	o_is_return <= is_return;
end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
(
	input wire clk,
	input wire reset,
	input wire i_valid,
	input wire isa_pkg::cond_t i_cond,
	input wire isa_pkg::reg_idx_t i_dest,
	input wire core_pkg::iaddr_t i_instr_addr,
	input wire isa_pkg::imm8_t i_imm8,
	input wire core_pkg::data_t i_op_a,
	input wire core_pkg::data_t i_op_b,
	input wire core_pkg::alu_sel_t i_alu_sel,
	input wire i_write_reg,
	input wire i_is_out,
	input wire i_is_test,
	input wire i_is_bf,
	input wire i_is_call,
	input wire i_is_return,
	output logic o_wb_en,
	output isa_pkg::reg_idx_t o_wb_reg,
	output core_pkg::data_t o_wb_data,
	output core_pkg::data_t o_out,
	output logic o_out_strobe,
	output logic o_jump,
	output core_pkg::iaddr_t o_target
);

logic z; // zero flag
logic n; // negative flag
core_pkg::iaddr_t link;
core_pkg::iaddr_t offset;
core_pkg::data_t alu_y;
logic cond_ok;
logic exec;

alu u_alu
(
	.i_a(i_op_a),
	.i_b(i_op_b),
	.i_sel(i_alu_sel),
	.o_y(alu_y)
);

// ==============================
// condition and commit
// ==============================
always_comb
begin
	cond_ok = 1'b1;
	case (i_cond)
		isa_pkg::COND_Z: cond_ok = z;
		isa_pkg::COND_NZ: cond_ok = !z;
		isa_pkg::COND_N: cond_ok = n;
		isa_pkg::COND_AL: cond_ok = 1'b1;
	endcase
end

assign exec = i_valid && cond_ok;

assign o_wb_en = exec && i_write_reg; // lands at the commit edge
assign o_wb_reg = i_dest;
assign o_wb_data = alu_y;

// branch offset is signed and relative to the branch itself
assign offset = {{(core_pkg::IADDR_WIDTH - isa_pkg::IMM8_WIDTH){i_imm8[isa_pkg::IMM8_WIDTH-1]}},
	i_imm8};
assign o_target = i_is_return ? link : i_instr_addr + offset;
assign o_jump = exec && (i_is_bf || i_is_call || i_is_return);

always_ff @(posedge clk)
begin
	if (reset)
	begin
		o_out <= '0;
		o_out_strobe <= 1'b0;
		z <= 1'b0;
		n <= 1'b0;
	end
	else
	begin
		o_out_strobe <= exec && i_is_out; // one cycle per out
		if (exec && i_is_out)
			o_out <= i_op_a;
		if (exec && i_is_test)
		begin
			z <= (i_op_a == '0);
			n <= i_op_a[core_pkg::DATA_WIDTH-1];
		end
	end
end

// single-entry return address
always_ff @(posedge clk)
begin
	if (exec && i_is_call)
		link <= i_instr_addr + core_pkg::iaddr_t'(1);
end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
(
	input wire clk,
	input wire reset,
	input wire i_jump,
	input wire core_pkg::iaddr_t i_target,
	output core_pkg::iaddr_t o_read_addr,
	input wire isa_pkg::instr_t i_read_data,
	output isa_pkg::instr_t o_instr,
	output core_pkg::iaddr_t o_instr_addr,
	output logic o_valid,
	output core_pkg::iaddr_t o_pc
);

core_pkg::iaddr_t pc;
core_pkg::fetch_state_t state; // says whether the registered slot may execute

// ==============================
// program counter and slot state
// ==============================
always_ff @(posedge clk)
begin
	if (reset)
	begin
		pc <= '0;
		state <= core_pkg::FETCH_SQUASH; // nothing fetched yet
	end
	else
	begin
		if (i_jump)
		begin
			// word read this cycle is on the wrong path
			pc <= i_target;
			state <= core_pkg::FETCH_SQUASH;
		end
		else
		begin
			pc <= pc + core_pkg::iaddr_t'(1);
			state <= core_pkg::FETCH_RUN;
		end
	end
end

// fetched word travels with its own address
always_ff @(posedge clk)
begin
	o_instr_addr <= pc;
	o_instr <= i_read_data;
end

assign o_valid = (state == core_pkg::FETCH_RUN);
assign o_read_addr = pc; // memory reads through in the same cycle
assign o_pc = pc;

endmodule

`default_nettype wire

// File: verilog/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem
(
	input wire clk,
	input wire i_write,
	input wire core_pkg::iaddr_t i_write_addr,
	input wire isa_pkg::instr_t i_write_data,
	input wire core_pkg::iaddr_t i_read_addr,
	output isa_pkg::instr_t o_read_data
);

isa_pkg::instr_t mem [core_pkg::IMEM_DEPTH]; // one instruction per word

// loading port
always_ff @(posedge clk)
begin
	if (i_write)
		mem[i_write_addr] <= i_write_data;
end

assign o_read_data = mem[i_read_addr]; // asynchronous read for fetch

endmodule

`default_nettype wire

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// ==============================
	// field widths
	// ==============================
	localparam int INSTR_WIDTH = 23;
	localparam int REG_IDX_WIDTH = 3;
	localparam int OPCODE_WIDTH = 4;
	localparam int COND_WIDTH = 2;
	localparam int IMM8_WIDTH = 8;

	// word layout
	// [22:20] rn, source and destination
	// [19:15] reserved and zero
	// [14:13] condition
	// [12]    reserved and zero
	// [11:8]  i8 opcode, then [7:4] i3 opcode and [3:0] i0 opcode
	// [7:0]   immediate
	typedef logic [INSTR_WIDTH-1:0] instr_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [COND_WIDTH-1:0] cond_t;
	typedef logic [IMM8_WIDTH-1:0] imm8_t;

	// i8 space, odd codes below 1000 take a register operand
	localparam opcode_t OP_ORI = 4'b0000;
	localparam opcode_t OP_ORR = 4'b0001;
	localparam opcode_t OP_ANDI = 4'b0010;
	localparam opcode_t OP_ANDR = 4'b0011;
	localparam opcode_t OP_ADDI = 4'b0100;
	localparam opcode_t OP_ADDR = 4'b0101;
	localparam opcode_t OP_SUBI = 4'b0110;
	localparam opcode_t OP_SUBR = 4'b0111;
	localparam opcode_t OP_LDI = 4'b1000;
	localparam opcode_t OP_BF = 4'b1101;
	localparam opcode_t OP_CALL = 4'b1110;
	localparam opcode_t OP_PREFIX = 4'b1111; // escape to the next space

	// i3 space
	localparam opcode_t I3_SHLZI = 4'b0000;
	localparam opcode_t I3_SHLZR = 4'b0001;
	localparam opcode_t I3_SHLOI = 4'b0010;
	localparam opcode_t I3_SHLOR = 4'b0011;
	localparam opcode_t I3_SHRZI = 4'b0100;
	localparam opcode_t I3_SHRZR = 4'b0101;
	localparam opcode_t I3_SHROI = 4'b0110;
	localparam opcode_t I3_SHROR = 4'b0111;
	localparam opcode_t I3_IN = 4'b1000;
	localparam opcode_t I3_OUT = 4'b1011;

	// i0 space
	localparam opcode_t I0_NOT = 4'b0000;
	localparam opcode_t I0_TEST = 4'b0010;
	localparam opcode_t I0_RETURN = 4'b0011;
	localparam opcode_t I0_NOP = 4'b0101;

	localparam cond_t COND_Z = 2'd0;
	localparam cond_t COND_NZ = 2'd1;
	localparam cond_t COND_N = 2'd2;
	localparam cond_t COND_AL = 2'd3;

	localparam instr_t INSTR_NOP = {3'd0, 5'd0, COND_AL, 1'b0, OP_PREFIX, OP_PREFIX, I0_NOP};

endpackage

`default_nettype wire

// File: verilog/pat_core.sv
`timescale 1ns/1ps
`default_nettype none

module pat_core
(
	input wire clk,
	input wire reset,
	input wire i_imem_write,
	input wire core_pkg::iaddr_t i_imem_addr,
	input wire isa_pkg::instr_t i_imem_data,
	input wire core_pkg::data_t i_in0,
	input wire core_pkg::data_t i_in1,
	input wire core_pkg::data_t i_in2,
	output wire core_pkg::data_t o_out,
	output wire o_out_strobe,
	output wire core_pkg::iaddr_t o_pc,
	output wire o_jump
);

// ==============================
// stage to stage wiring
// ==============================
wire core_pkg::iaddr_t imem_read_addr;
wire isa_pkg::instr_t imem_read_data;

wire isa_pkg::instr_t f_instr; // fetch slot
wire core_pkg::iaddr_t f_instr_addr;
wire f_valid;

wire isa_pkg::reg_idx_t rf_read_reg [core_pkg::NUM_READ_PORTS];
wire core_pkg::data_t rf_read_data [core_pkg::NUM_READ_PORTS];

wire d_valid; // decode slot
wire isa_pkg::cond_t d_cond;
wire isa_pkg::reg_idx_t d_dest;
wire core_pkg::iaddr_t d_instr_addr;
wire isa_pkg::imm8_t d_imm8;
wire core_pkg::data_t d_op_a;
wire core_pkg::data_t d_op_b;
wire core_pkg::alu_sel_t d_alu_sel;
wire d_write_reg;
wire d_is_out;
wire d_is_test;
wire d_is_bf;
wire d_is_call;
wire d_is_return;

wire wb_en;
wire isa_pkg::reg_idx_t wb_reg;
wire core_pkg::data_t wb_data;
wire core_pkg::iaddr_t jump_target;

inst_mem u_inst_mem
(
	.clk(clk),
	.i_write(i_imem_write),
	.i_write_addr(i_imem_addr),
	.i_write_data(i_imem_data),
	.i_read_addr(imem_read_addr),
	.o_read_data(imem_read_data)
);

fetch_unit u_fetch
(
	.clk(clk),
	.reset(reset),
	.i_jump(o_jump),
	.i_target(jump_target),
	.o_read_addr(imem_read_addr),
	.i_read_data(imem_read_data),
	.o_instr(f_instr),
	.o_instr_addr(f_instr_addr),
	.o_valid(f_valid),
	.o_pc(o_pc)
);

decode_stage u_decode
(
	.clk(clk),
	.reset(reset),
	.i_instr(f_instr),
	.i_instr_addr(f_instr_addr),
	.i_valid(f_valid),
	.i_jump(o_jump),
	.o_read_reg(rf_read_reg),
	.i_read_data(rf_read_data),
	.i_wb_en(wb_en),
	.i_wb_reg(wb_reg),
	.i_wb_data(wb_data),
	.i_in0(i_in0),
	.i_in1(i_in1),
	.i_in2(i_in2),
	.o_valid(d_valid),
	.o_cond(d_cond),
	.o_dest(d_dest),
	.o_instr_addr(d_instr_addr),
	.o_imm8(d_imm8),
	.o_op_a(d_op_a),
	.o_op_b(d_op_b),
	.o_alu_sel(d_alu_sel),
	.o_write_reg(d_write_reg),
	.o_is_out(d_is_out),
	.o_is_test(d_is_test),
	.o_is_bf(d_is_bf),
	.o_is_call(d_is_call),
	.o_is_return(d_is_return)
);

reg_file u_reg_file
(
	.clk(clk),
	.i_read_reg(rf_read_reg),
	.o_read_data(rf_read_data),
	.i_write_en(wb_en),
	.i_write_reg(wb_reg),
	.i_write_data(wb_data)
);

execute_stage u_execute
(
	.clk(clk),
	.reset(reset),
	.i_valid(d_valid),
	.i_cond(d_cond),
	.i_dest(d_dest),
	.i_instr_addr(d_instr_addr),
	.i_imm8(d_imm8),
	.i_op_a(d_op_a),
	.i_op_b(d_op_b),
	.i_alu_sel(d_alu_sel),
	.i_write_reg(d_write_reg),
	.i_is_out(d_is_out),
	.i_is_test(d_is_test),
	.i_is_bf(d_is_bf),
	.i_is_call(d_is_call),
	.i_is_return(d_is_return),
	.o_wb_en(wb_en),
	.o_wb_reg(wb_reg),
	.o_wb_data(wb_data),
	.o_out(o_out),
	.o_out_strobe(o_out_strobe),
	.o_jump(o_jump),
	.o_target(jump_target)
);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
	input wire clk,
	input wire isa_pkg::reg_idx_t i_read_reg [core_pkg::NUM_READ_PORTS],
	output core_pkg::data_t o_read_data [core_pkg::NUM_READ_PORTS],
	input wire i_write_en,
	input wire isa_pkg::reg_idx_t i_write_reg,
	input wire core_pkg::data_t i_write_data
);

core_pkg::data_t regs [core_pkg::NUM_REGS];

always_ff @(posedge clk)
begin
	if (i_write_en)
		regs[i_write_reg] <= i_write_data;
end

// write-through on every read port
for (genvar p = 0; p < core_pkg::NUM_READ_PORTS; p++)
begin : g_read
	assign o_read_data[p] = (i_write_en && i_write_reg == i_read_reg[p]) ?
		i_write_data : regs[i_read_reg[p]];
end

endmodule

`default_nettype wire
